//--- dv/memory_bus_sva.sv
// Avalon master assertions on burst count, exclusive commands, back-pressure hold and reset state
`timescale 1ns/1ns

module memory_bus_sva (
    input logic                     clk,
    input logic                     rst_n,
    input mem_req_pkg::burst_cmd_t  cmd,
    input mem_bus_pkg::dword_addr_t avm_address,
    input mem_bus_pkg::dword_t      avm_writedata,
    input mem_bus_pkg::byteen_t     avm_byteenable,
    input mem_bus_pkg::beat_count_t avm_burstcount,
    input logic                     avm_read,
    input logic                     avm_write,
    input logic                     avm_waitrequest
);

    int         error_count = 0;        // failures seen so far
    logic [4:0] ceil_beats;             // dwords touched by offset + length

    assign ceil_beats = (5'(cmd.offset) + 5'(cmd.length) + 5'd3) >> 2;

    // ----------------------------------------
    // burst shape
    // ----------------------------------------
    a_burstcount: assert property (@(posedge clk) disable iff (!rst_n)
        (avm_read || avm_write) |-> (avm_burstcount == ceil_beats[3:0])
            && (avm_burstcount <= mem_bus_pkg::MAX_BEATS))
        else begin
            error_count++;
            $error("avm_burstcount %0d breaks the ceiling rule", avm_burstcount);
        end

    a_exclusive: assert property (@(posedge clk) !(avm_read && avm_write))
        else begin
            error_count++;
            $error("avm_read and avm_write high together");
        end

    // ----------------------------------------
    // back-pressure and reset
    // ----------------------------------------
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_burstcount) && $stable(avm_byteenable)
            && $stable(avm_writedata) && $stable(avm_read) && $stable(avm_write))
        else begin
            error_count++;
            $error("command changed under waitrequest");
        end

    a_reset: assert property (@(posedge clk) !rst_n |-> (!avm_read && !avm_write))
        else begin
            error_count++;
            $error("bus command during reset");
        end

endmodule

//--- dv/memory_bus_tb.sv
// Memory bus testbench with CPU port stimulus, Avalon memory model, reference bytes and checks
`timescale 1ns/1ns

module memory_bus_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int MEM_BYTES      = 256;    // 64 dwords

    logic                     clk;
    logic                     rst_n;
    logic                     read_do;
    mem_req_pkg::byte_addr_t  read_address;
    mem_req_pkg::read_len_t   read_length;
    logic                     read_done;
    mem_req_pkg::qword_t      read_data;
    logic                     write_do;
    mem_req_pkg::byte_addr_t  write_address;
    mem_req_pkg::write_len_t  write_length;
    mem_bus_pkg::dword_t      write_data;
    logic                     write_done;
    mem_bus_pkg::dword_addr_t avm_address;
    mem_bus_pkg::dword_t      avm_writedata;
    mem_bus_pkg::byteen_t     avm_byteenable;
    mem_bus_pkg::beat_count_t avm_burstcount;
    logic                     avm_read;
    logic                     avm_write;
    logic                     avm_waitrequest;
    logic                     avm_readdatavalid;
    mem_bus_pkg::dword_t      avm_readdata;

    logic [7:0]  model_bytes [MEM_BYTES];   // memory behind the Avalon port
    logic [7:0]  ref_bytes   [MEM_BYTES];   // what the CPU side should see
    logic [31:0] lfsr;
    logic [31:0] draw;
    logic [5:0]  rd_next;                   // next dword of a read burst
    logic [5:0]  wr_next;
    int          rd_left;
    int          wr_left;
    int          value_errors;
    int          timeout_errors;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

    memory_bus_top #(.WRITE_FIRST(1'b1)) i_memory_bus_top (.*);

    bind avalon_burst_master memory_bus_sva i_memory_bus_sva (.*);

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 37 + 11);             // odd multiplier keeps all 256 bytes distinct
    endfunction

    // requested bytes at byte 0 with the upper bytes zero
    function automatic mem_req_pkg::qword_t expected_read(input int addr, input int len);
        mem_req_pkg::qword_t q;
        q = '0;
        for (int i = 0; i < len; i++) begin
            q[i*8 +: 8] = ref_bytes[addr + i];
        end
        return q;
    endfunction

    task automatic value_error(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
        value_errors++;
        $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp_v, got_v);
    endtask

    // ----------------------------------------
    // Avalon memory model
    // ----------------------------------------
    always @(posedge clk) begin
        if (avm_read && !avm_waitrequest) begin
            rd_next = avm_address[5:0];
            rd_left = int'(avm_burstcount);
        end
        if (avm_write && !avm_waitrequest) begin
            if (wr_left == 0) begin         // beat 0 opens the burst
                wr_next = avm_address[5:0];
                wr_left = int'(avm_burstcount);
            end
            for (int b = 0; b < 4; b++) begin
                if (avm_byteenable[b]) model_bytes[{wr_next, 2'(b)}] = avm_writedata[b*8 +: 8];
            end
            wr_next++;
            wr_left--;
        end
        if (avm_readdatavalid) begin
            rd_next++;
            rd_left--;
        end
    end

    always @(negedge clk) begin
        take_bits(2, draw);
        avm_waitrequest = (draw[1:0] == 2'b11);                 // stall about one in four
        take_bits(2, draw);
        avm_readdatavalid = (rd_left > 0) && (draw[1:0] != 2'b00);
        avm_readdata = {model_bytes[{rd_next, 2'd3}], model_bytes[{rd_next, 2'd2}],
                        model_bytes[{rd_next, 2'd1}], model_bytes[{rd_next, 2'd0}]};
    end

    // ----------------------------------------
    // CPU side tasks that start and end at a falling edge
    // ----------------------------------------
    task automatic check_issue(input bit is_write);
        @(negedge clk);
        assert (!avm_read && !avm_write) else value_error("avm_read|avm_write", 0, 1);
        @(negedge clk);                     // two edges after do was sampled
        assert (is_write ? avm_write : avm_read)
            else value_error(is_write ? "avm_write" : "avm_read", 1, 0);
    endtask

    task automatic wait_done(output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            seen = read_done || write_done;
            n++;
        end
        if (!seen) begin
            timeout_errors++;
            $display("timeout: no read_done or write_done within %0d cycles", TIMEOUT_CYCLES);
        end
    endtask

    // done low one cycle later and a held do kept through the rest cycle
    task automatic close_request();
        @(negedge clk);
        assert (!read_done && !write_done) else value_error("read_done|write_done", 0, 1);
        @(negedge clk);
        read_do  = 1'b0;
        write_do = 1'b0;
    endtask

    task automatic read_and_check(input int addr, input int len, input bit hold);
        bit                  seen;
        mem_req_pkg::qword_t expected;
        expected     = expected_read(addr, len);
        read_address = mem_req_pkg::byte_addr_t'(addr);
        read_length  = mem_req_pkg::read_len_t'(len);
        read_do      = 1'b1;
        check_issue(1'b0);
        wait_done(seen);
        assert (!seen || read_done) else value_error("read_done", 1, 64'(read_done));
        assert (!seen || read_data === expected)
            else value_error("read_data", expected, read_data);
        read_do = hold;                     // held do must not be served twice
        close_request();
    endtask

    task automatic write_and_check(input int addr, input int len, input logic [31:0] data,
                                   input bit hold);
        bit seen;
        write_address = mem_req_pkg::byte_addr_t'(addr);
        write_length  = mem_req_pkg::write_len_t'(len);
        write_data    = data;
        write_do      = 1'b1;
        check_issue(1'b1);
        wait_done(seen);
        assert (!seen || write_done) else value_error("write_done", 1, 64'(write_done));
        for (int i = 0; i < len; i++) begin
            ref_bytes[addr + i] = data[i*8 +: 8];
        end
        write_do = hold;
        close_request();
    endtask

    // write wins and the waiting read then sees the new bytes
    task automatic both_ports(input int addr, input int len, input logic [31:0] data);
        bit                  seen;
        int                  base;
        mem_req_pkg::qword_t expected;
        base          = addr & ~3;
        write_address = mem_req_pkg::byte_addr_t'(addr);
        write_length  = mem_req_pkg::write_len_t'(len);
        write_data    = data;
        read_address  = mem_req_pkg::byte_addr_t'(base);
        read_length   = 4'd8;
        write_do      = 1'b1;
        read_do       = 1'b1;
        check_issue(1'b1);
        wait_done(seen);
        assert (write_done && !read_done) else value_error("write_done", 1, 64'(write_done));
        for (int i = 0; i < len; i++) begin
            ref_bytes[addr + i] = data[i*8 +: 8];
        end
        write_do = 1'b0;
        expected = expected_read(base, 8);
        wait_done(seen);
        assert (!seen || read_done) else value_error("read_done", 1, 64'(read_done));
        assert (!seen || read_data === expected)
            else value_error("read_data", expected, read_data);
        read_do = 1'b0;
        close_request();
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!avm_read && !avm_write && !read_done && !write_done)
                else value_error("avm_read|avm_write|done", 0, 1);
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        int n;
        int k;
        read_do           = 1'b0;
        read_address      = '0;
        read_length       = '0;
        write_do          = 1'b0;
        write_address     = '0;
        write_length      = '0;
        write_data        = '0;
        avm_waitrequest   = 1'b0;
        avm_readdatavalid = 1'b0;
        avm_readdata      = '0;
        lfsr              = 32'd66711;
        rd_next           = '0;
        wr_next           = '0;
        rd_left           = 0;
        wr_left           = 0;
        value_errors      = 0;
        timeout_errors    = 0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            model_bytes[a] = fill_byte(a);
            ref_bytes[a]   = fill_byte(a);
        end

        n = 0;
        while (!rst_n && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            timeout_errors++;
            $display("timeout: reset was never released");
        end
        @(negedge clk);
        @(negedge clk);

        // reads of every length at every offset
        for (int len = 1; len <= 8; len++) begin
            for (int off = 0; off < 4; off++) begin
                read_and_check((len - 1) * 28 + 5 * off, len, 1'b0);
            end
        end

        // writes, each followed by a read over the area
        k = 0;
        for (int len = 1; len <= 4; len++) begin
            for (int off = 0; off < 4; off++) begin
                k++;
                write_and_check(128 + (len - 1) * 20 + 5 * off, len, 32'h9E37_79B9 * k, 1'b0);
                read_and_check((128 + (len - 1) * 20 + 5 * off) & ~3, 8, 1'b0);
            end
        end

        // both ports in the same cycle
        for (int off = 0; off < 4; off++) begin
            both_ports(220 + 5 * off, off + 1, 32'hA5C3_0F69 ^ (32'h0101_0101 * off));
        end

        // do held through the done cycle
        read_and_check(70, 6, 1'b1);
        check_quiet(6);
        read_and_check(70, 6, 1'b0);
        write_and_check(97, 3, 32'h0BAD_F00D, 1'b1);
        check_quiet(6);
        read_and_check(96, 8, 1'b0);

        $display("errors: value %0d, timeout %0d, assertion %0d", value_errors, timeout_errors,
                 i_memory_bus_top.i_avalon_burst_master.i_memory_bus_sva.error_count);
        if (value_errors + timeout_errors
            + i_memory_bus_top.i_avalon_burst_master.i_memory_bus_sva.error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                   // released away from the rising edge
    end

endmodule

//--- project.f
verilog/mem_bus_pkg.sv
verilog/mem_req_pkg.sv
verilog/mem_request_arbiter.sv
verilog/burst_planner.sv
verilog/avalon_burst_master.sv
verilog/read_data_aligner.sv
verilog/memory_bus_top.sv
dv/tb_clock_gen.sv
dv/memory_bus_sva.sv
dv/memory_bus_tb.sv

//--- verilog/avalon_burst_master.sv
// Avalon burst master: command FSM, write beat stepping, read beat collection
`timescale 1ns/1ns

module avalon_burst_master (
    input  logic                     clk,
    input  logic                     rst_n,

    // planned burst
    input  logic                     cmd_valid,
    input  mem_req_pkg::burst_cmd_t  cmd,

    // avalon master
    output mem_bus_pkg::dword_addr_t avm_address,
    output mem_bus_pkg::dword_t      avm_writedata,
    output mem_bus_pkg::byteen_t     avm_byteenable,
    output mem_bus_pkg::beat_count_t avm_burstcount,
    output logic                     avm_read,
    output logic                     avm_write,
    input  logic                     avm_waitrequest,
    input  logic                     avm_readdatavalid,
    input  mem_bus_pkg::dword_t      avm_readdata,

    // to aligner and arbiter
    output mem_bus_pkg::beat_buf_t   beats,
    output logic                     xfer_done
);

    typedef enum logic [2:0] {
        MST_IDLE,
        MST_READ_CMD,
        MST_READ_DATA,
        MST_WRITE,
        MST_DONE
    } mst_state_e;

    mst_state_e state;

    logic [$clog2(mem_bus_pkg::MAX_BEATS)-1:0] rd_beat;   // next read beat slot
    logic                                      wr_beat;   // 0 or 1, writes are two beats max

    logic issue;
    logic is_read;
    logic wr_accept;
    logic wr_last;
    logic rd_last;

    // ----------------------------------------
    // bus outputs
    // ----------------------------------------
    // command goes out in the cmd_valid cycle, no extra register stage
    assign issue   = (state == MST_IDLE) && cmd_valid;
    assign is_read = (cmd.op == mem_req_pkg::OP_READ);

    assign avm_read  = (issue && is_read) || (state == MST_READ_CMD);
    assign avm_write = (issue && !is_read) || (state == MST_WRITE);

    // planner holds cmd for the whole burst
    assign avm_address    = cmd.dword_addr;
    assign avm_burstcount = cmd.beat_count;
    assign avm_writedata  = wr_beat ? cmd.wdata_1 : cmd.wdata_0;
    assign avm_byteenable = is_read ? 4'hF : (wr_beat ? cmd.byteen_1 : cmd.byteen_0);

    assign wr_accept = avm_write && !avm_waitrequest;
    assign wr_last   = mem_bus_pkg::beat_count_t'(wr_beat) == cmd.beat_count - 4'd1;
    assign rd_last   = mem_bus_pkg::beat_count_t'(rd_beat) == cmd.beat_count - 4'd1;

    assign xfer_done = (state == MST_DONE);

    // ----------------------------------------
    // burst FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= MST_IDLE;
            rd_beat <= '0;
            wr_beat <= 1'b0;
        end else begin
            case (state)
                MST_IDLE: begin
                    if (cmd_valid) begin
                        if (is_read) begin
                            state <= avm_waitrequest ? MST_READ_CMD : MST_READ_DATA;
                        end else if (wr_accept && wr_last) begin
                            state <= MST_DONE;          // single beat write taken at once
                        end else begin
                            state <= MST_WRITE;
                            if (wr_accept) wr_beat <= 1'b1;
                        end
                    end
                end
                MST_READ_CMD: begin
                    if (!avm_waitrequest) state <= MST_READ_DATA;
                end
                MST_READ_DATA: begin
                    if (avm_readdatavalid) begin
                        if (rd_last) state <= MST_DONE;
                        else         rd_beat <= rd_beat + 1'b1;
                    end
                end
                MST_WRITE: begin
                    if (wr_accept) begin
                        if (wr_last) state <= MST_DONE;
                        else         wr_beat <= 1'b1;
                    end
                end
                default: begin                          // MST_DONE
                    state   <= MST_IDLE;
                    rd_beat <= '0;
                    wr_beat <= 1'b0;
                end
            endcase
        end
    end

    // ----------------------------------------
    // read beat buffer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == MST_READ_DATA && avm_readdatavalid) begin
            beats[{rd_beat, 5'b00000} +: 32] <= avm_readdata;
        end
    end

endmodule

//--- verilog/burst_planner.sv
// Burst planner: dword address, beat count, byte enables, shifted write dwords
`timescale 1ns/1ns

module burst_planner (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    req_valid,
    input  mem_req_pkg::mem_req_t   req,

    output logic                    cmd_valid,
    output mem_req_pkg::burst_cmd_t cmd
);

    logic [1:0]                offset;
    logic [3:0]                span;         // offset + length, up to 11
    mem_bus_pkg::beat_count_t  beat_count;
    logic [7:0]                byte_mask;    // enables over two dwords
    logic [63:0]               shifted_data;

    // ----------------------------------------
    // burst shape
    // ----------------------------------------
    assign offset = req.address[1:0];
    assign span   = {2'b00, offset} + req.length;

    // ceiling of span / 4
    assign beat_count = (span + 4'd3) >> 2;

    // ----------------------------------------
    // write lanes
    // ----------------------------------------
    // length ones moved up to the first addressed byte
    assign byte_mask    = ((8'd1 << req.length) - 8'd1) << offset;
    assign shifted_data = {32'd0, req.data} << {offset, 3'b000};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= req_valid;
        end
    end

    // command stays put until the next request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            cmd.op         <= req.op;
            cmd.dword_addr <= req.address[31:2];
            cmd.beat_count <= beat_count;
            cmd.byteen_0   <= byte_mask[3:0];
            cmd.byteen_1   <= byte_mask[7:4];
            cmd.wdata_0    <= shifted_data[31:0];
            cmd.wdata_1    <= shifted_data[63:32];
            cmd.offset     <= offset;
            cmd.length     <= req.length;
        end
    end

endmodule

//--- verilog/mem_bus_pkg.sv
// Avalon bus widths: dword, byte enables, dword address, burst count, read beat buffer

package mem_bus_pkg;

    // ----------------------------------------
    // bus side words
    // ----------------------------------------
    typedef logic [31:0] dword_t;          // one data beat
    typedef logic [3:0]  byteen_t;         // enables of one dword
    typedef logic [29:0] dword_addr_t;     // byte address bits 31:2

    // ----------------------------------------
    // bursts
    // ----------------------------------------
    typedef logic [3:0]  beat_count_t;     // avalon burstcount
    typedef logic [95:0] beat_buf_t;       // up to three read beats, beat 0 lowest

    // an 8 byte read at offset 3 spans three dwords
    localparam int MAX_BEATS = 3;

endpackage

//--- verilog/mem_req_pkg.sv
// CPU request types, request and burst command structs, operation enum

package mem_req_pkg;

    // ----------------------------------------
    // cpu port fields
    // ----------------------------------------
    typedef logic [31:0] byte_addr_t;      // physical byte address
    typedef logic [3:0]  read_len_t;       // 1..8 bytes
    typedef logic [2:0]  write_len_t;      // 1..4 bytes
    typedef logic [63:0] qword_t;          // right aligned read result

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // ----------------------------------------
    // arbiter -> planner
    // ----------------------------------------
    typedef struct packed {
        mem_op_e             op;
        byte_addr_t          address;
        read_len_t           length;       // write length zero extended
        mem_bus_pkg::dword_t data;         // write data, right aligned
    } mem_req_t;

    // ----------------------------------------
    // planner -> master and aligner
    // ----------------------------------------
    typedef struct packed {
        mem_op_e                  op;
        mem_bus_pkg::dword_addr_t dword_addr;  // first dword of the burst
        mem_bus_pkg::beat_count_t beat_count;
        mem_bus_pkg::byteen_t     byteen_0;    // write beat 0
        mem_bus_pkg::byteen_t     byteen_1;    // write beat 1
        mem_bus_pkg::dword_t      wdata_0;
        mem_bus_pkg::dword_t      wdata_1;
        logic [1:0]               offset;      // byte offset in first dword
        read_len_t                length;
    } burst_cmd_t;

endpackage

//--- verilog/mem_request_arbiter.sv
// Request arbiter: read/write port select, request register, done pulses
`timescale 1ns/1ns

module mem_request_arbiter #(
    parameter bit WRITE_FIRST = 1'b1
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // cpu read port
    input  logic                    read_do,
    input  mem_req_pkg::byte_addr_t read_address,
    input  mem_req_pkg::read_len_t  read_length,
    output logic                    read_done,

    // cpu write port
    input  logic                    write_do,
    input  mem_req_pkg::byte_addr_t write_address,
    input  mem_req_pkg::write_len_t write_length,
    input  mem_bus_pkg::dword_t     write_data,
    output logic                    write_done,

    // burst path
    input  logic                    xfer_done,
    output logic                    req_valid,
    output mem_req_pkg::mem_req_t   req
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_DONE,
        ARB_REST
    } arb_state_e;

    arb_state_e state;
    logic       pick_write;
    logic       pick_read;

    // ----------------------------------------
    // port select
    // ----------------------------------------
    assign pick_write = write_do && (WRITE_FIRST || !read_do);
    assign pick_read  = read_do && !pick_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_IDLE;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (pick_write || pick_read) begin
                        state     <= ARB_BUSY;
                        req_valid <= 1'b1;          // one cycle strobe
                    end
                end
                ARB_BUSY: begin
                    if (xfer_done) state <= ARB_DONE;
                end
                ARB_DONE: state <= ARB_REST;        // do still high here
                default:  state <= ARB_IDLE;        // do dropped by now
            endcase
        end
    end

    // ----------------------------------------
    // request register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && pick_write) begin
            req.op      <= mem_req_pkg::OP_WRITE;
            req.address <= write_address;
            req.length  <= mem_req_pkg::read_len_t'(write_length);
            req.data    <= write_data;
        end else if (state == ARB_IDLE && pick_read) begin
            req.op      <= mem_req_pkg::OP_READ;
            req.address <= read_address;
            req.length  <= read_length;
            req.data    <= '0;
        end
    end

    // done follows the held op
    assign read_done  = (state == ARB_DONE) && (req.op == mem_req_pkg::OP_READ);
    assign write_done = (state == ARB_DONE) && (req.op == mem_req_pkg::OP_WRITE);

endmodule

//--- verilog/memory_bus_top.sv
// Memory bus top level: arbiter, burst planner, Avalon master, read aligner
`timescale 1ns/1ns

module memory_bus_top #(
    parameter bit WRITE_FIRST = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // cpu read port
    input  logic                     read_do,
    input  mem_req_pkg::byte_addr_t  read_address,
    input  mem_req_pkg::read_len_t   read_length,
    output logic                     read_done,
    output mem_req_pkg::qword_t      read_data,

    // cpu write port
    input  logic                     write_do,
    input  mem_req_pkg::byte_addr_t  write_address,
    input  mem_req_pkg::write_len_t  write_length,
    input  mem_bus_pkg::dword_t      write_data,
    output logic                     write_done,

    // avalon master
    output mem_bus_pkg::dword_addr_t avm_address,
    output mem_bus_pkg::dword_t      avm_writedata,
    output mem_bus_pkg::byteen_t     avm_byteenable,
    output mem_bus_pkg::beat_count_t avm_burstcount,
    output logic                     avm_read,
    output logic                     avm_write,
    input  logic                     avm_waitrequest,
    input  logic                     avm_readdatavalid,
    input  mem_bus_pkg::dword_t      avm_readdata
);

    logic                    req_valid;
    mem_req_pkg::mem_req_t   req;
    logic                    cmd_valid;
    mem_req_pkg::burst_cmd_t cmd;
    mem_bus_pkg::beat_buf_t  beats;
    logic                    xfer_done;

    // ----------------------------------------
    // input side
    // ----------------------------------------
    mem_request_arbiter #(
        .WRITE_FIRST    (WRITE_FIRST)
    ) i_mem_request_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .read_do        (read_do),
        .read_address   (read_address),
        .read_length    (read_length),
        .read_done      (read_done),        //output
        .write_do       (write_do),
        .write_address  (write_address),
        .write_length   (write_length),
        .write_data     (write_data),
        .write_done     (write_done),       //output
        .xfer_done      (xfer_done),
        .req_valid      (req_valid),        //output
        .req            (req)               //output mem_req_t
    );

    burst_planner i_burst_planner (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .cmd_valid      (cmd_valid),        //output
        .cmd            (cmd)               //output burst_cmd_t
    );

    // ----------------------------------------
    // output side
    // ----------------------------------------
    avalon_burst_master i_avalon_burst_master (
        .clk                (clk),
        .rst_n              (rst_n),
        .cmd_valid          (cmd_valid),
        .cmd                (cmd),
        .avm_address        (avm_address),
        .avm_writedata      (avm_writedata),
        .avm_byteenable     (avm_byteenable),
        .avm_burstcount     (avm_burstcount),
        .avm_read           (avm_read),
        .avm_write          (avm_write),
        .avm_waitrequest    (avm_waitrequest),
        .avm_readdatavalid  (avm_readdatavalid),
        .avm_readdata       (avm_readdata),
        .beats              (beats),            //output [95:0]
        .xfer_done          (xfer_done)         //output
    );

    read_data_aligner i_read_data_aligner (
        .clk            (clk),
        .rst_n          (rst_n),
        .xfer_done      (xfer_done),
        .cmd            (cmd),
        .beats          (beats),
        .read_data      (read_data)         //output [63:0]
    );

endmodule

//--- verilog/read_data_aligner.sv
// Read data aligner: byte extraction from read beats into the 64-bit result
`timescale 1ns/1ns

module read_data_aligner (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    xfer_done,
    input  mem_req_pkg::burst_cmd_t cmd,
    input  mem_bus_pkg::beat_buf_t  beats,

    output mem_req_pkg::qword_t     read_data
);

    mem_bus_pkg::beat_buf_t aligned;     // first wanted byte at bit 0
    mem_req_pkg::qword_t    trimmed;

    // ----------------------------------------
    // shift and trim
    // ----------------------------------------
    always_comb begin
        aligned = beats >> {cmd.offset, 3'b000};
        for (int i = 0; i < 8; i++) begin
            trimmed[i*8 +: 8] = (i < cmd.length) ? aligned[i*8 +: 8] : 8'h00;
        end
    end

    // held until the next read completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (xfer_done && cmd.op == mem_req_pkg::OP_READ) begin
            read_data <= trimmed;
        end
    end

endmodule
